/* src/mastermind_pkg.sv */
`default_nettype none

package mastermind_pkg;

    localparam int PEGS_PER_ROW = 4;

    typedef logic [2:0] colour_t;     // Eight peg colours
    typedef logic [1:0] slot_t;
    typedef logic [2:0] peg_count_t;  // 0 to 4
    typedef logic [3:0] score_t;      // Wraps modulo 16
    typedef logic [3:0] guess_idx_t;

    // Slot 0 sits in the low bits
    typedef struct packed {
        colour_t slot_3;
        colour_t slot_2;
        colour_t slot_1;
        colour_t slot_0;
    } peg_row_t;

    typedef struct packed {
        peg_count_t red;
        peg_count_t white;
    } feedback_t;

    // Each slot has an entry state and a wait-for-release state
    typedef enum logic [4:0] {
        CODE_1,
        CODE_1_WAIT,
        CODE_2,
        CODE_2_WAIT,
        CODE_3,
        CODE_3_WAIT,
        CODE_4,
        CODE_4_WAIT,
        GUESS_1,
        GUESS_1_WAIT,
        GUESS_2,
        GUESS_2_WAIT,
        GUESS_3,
        GUESS_3_WAIT,
        GUESS_4,
        GUESS_4_WAIT,
        SCORE_START,
        SCORE_WAIT
    } entry_state_e;

endpackage

`default_nettype wire

/* src/peg_entry_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module peg_entry_fsm import mastermind_pkg::*; (
    input  wire   clock,
    input  wire   resetn,
    input  wire   load_i,
    input  wire   game_end_i,
    output logic  write_code_o,
    output logic  write_guess_o,
    output slot_t slot_o,
    output logic  score_start_o
);

    // Last cycle of SCORE_WAIT lines up with score_valid from the scorer
    localparam logic [2:0] WAIT_LAST = 3'(PEGS_PER_ROW);

    entry_state_e state_q;
    entry_state_e state_d;
    logic [2:0]   wait_cnt_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CODE_1:       state_d = load_i ? CODE_1_WAIT : CODE_1;
            CODE_1_WAIT:  state_d = load_i ? CODE_1_WAIT : CODE_2;
            CODE_2:       state_d = load_i ? CODE_2_WAIT : CODE_2;
            CODE_2_WAIT:  state_d = load_i ? CODE_2_WAIT : CODE_3;
            CODE_3:       state_d = load_i ? CODE_3_WAIT : CODE_3;
            CODE_3_WAIT:  state_d = load_i ? CODE_3_WAIT : CODE_4;
            CODE_4:       state_d = load_i ? CODE_4_WAIT : CODE_4;
            CODE_4_WAIT:  state_d = load_i ? CODE_4_WAIT : GUESS_1;
            GUESS_1:      state_d = load_i ? GUESS_1_WAIT : GUESS_1;
            GUESS_1_WAIT: state_d = load_i ? GUESS_1_WAIT : GUESS_2;
            GUESS_2:      state_d = load_i ? GUESS_2_WAIT : GUESS_2;
            GUESS_2_WAIT: state_d = load_i ? GUESS_2_WAIT : GUESS_3;
            GUESS_3:      state_d = load_i ? GUESS_3_WAIT : GUESS_3;
            GUESS_3_WAIT: state_d = load_i ? GUESS_3_WAIT : GUESS_4;
            GUESS_4:      state_d = load_i ? GUESS_4_WAIT : GUESS_4;
            GUESS_4_WAIT: state_d = load_i ? GUESS_4_WAIT : SCORE_START;
            SCORE_START:  state_d = SCORE_WAIT;
            SCORE_WAIT: begin
                if (wait_cnt_q == WAIT_LAST) begin
                    state_d = game_end_i ? CODE_1 : GUESS_1;
                end
            end
            default:      state_d = CODE_1;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state_q    <= CODE_1;
            wait_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == SCORE_WAIT) begin
                wait_cnt_q <= wait_cnt_q + 3'd1;
            end else begin
                wait_cnt_q <= '0;
            end
        end
    end

    always_comb begin
        case (state_q)
            CODE_1, CODE_1_WAIT, GUESS_1, GUESS_1_WAIT: slot_o = slot_t'(0);
            CODE_2, CODE_2_WAIT, GUESS_2, GUESS_2_WAIT: slot_o = slot_t'(1);
            CODE_3, CODE_3_WAIT, GUESS_3, GUESS_3_WAIT: slot_o = slot_t'(2);
            CODE_4, CODE_4_WAIT, GUESS_4, GUESS_4_WAIT: slot_o = slot_t'(3);
            default:                                    slot_o = slot_t'(0);
        endcase
    end

    // Presses outside entry states are dropped here
    assign write_code_o  = load_i && (state_q inside {CODE_1, CODE_2, CODE_3, CODE_4});
    assign write_guess_o = load_i && (state_q inside {GUESS_1, GUESS_2, GUESS_3, GUESS_4});
    assign score_start_o = (state_q == SCORE_START);

    a_one_write: assert property (
        @(posedge clock) disable iff (!resetn)
        !(write_code_o && write_guess_o)
    );

endmodule

`default_nettype wire

/* src/peg_store.sv */
`timescale 1ns/1ps
`default_nettype none

module peg_store import mastermind_pkg::*; (
    input  wire      clock,
    input  wire      resetn,
    input  colour_t  colour_i,
    input  wire      write_code_i,
    input  wire      write_guess_i,
    input  slot_t    slot_i,
    output peg_row_t code_o,
    output peg_row_t guess_o
);

    peg_row_t code_q;
    peg_row_t guess_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            code_q  <= '0;
            guess_q <= '0;
        end else if (write_code_i) begin
            case (slot_i)
                2'd0:    code_q.slot_0 <= colour_i;
                2'd1:    code_q.slot_1 <= colour_i;
                2'd2:    code_q.slot_2 <= colour_i;
                default: code_q.slot_3 <= colour_i;
            endcase
        end else if (write_guess_i) begin
            case (slot_i)
                2'd0:    guess_q.slot_0 <= colour_i;
                2'd1:    guess_q.slot_1 <= colour_i;
                2'd2:    guess_q.slot_2 <= colour_i;
                default: guess_q.slot_3 <= colour_i;
            endcase
        end
    end

    assign code_o  = code_q;
    assign guess_o = guess_q;

endmodule

`default_nettype wire

/* src/peg_scorer.sv */
`timescale 1ns/1ps
`default_nettype none

module peg_scorer import mastermind_pkg::*; (
    input  wire       clock,
    input  wire       resetn,
    input  wire       start_i,
    input  peg_row_t  code_i,
    input  peg_row_t  guess_i,
    output feedback_t feedback_o,
    output logic      score_valid_o
);

    colour_t                 code_c  [PEGS_PER_ROW];
    colour_t                 guess_c [PEGS_PER_ROW];
    logic [PEGS_PER_ROW-1:0] exact;
    logic [PEGS_PER_ROW-1:0] used_q;   // Guess slots already paired as white
    slot_t                   idx_q;    // Code slot under compare
    logic                    busy_q;
    logic                    valid_q;
    feedback_t               fb_q;
    logic                    hit;
    slot_t                   hit_slot;

    assign code_c[0]  = code_i.slot_0;
    assign code_c[1]  = code_i.slot_1;
    assign code_c[2]  = code_i.slot_2;
    assign code_c[3]  = code_i.slot_3;
    assign guess_c[0] = guess_i.slot_0;
    assign guess_c[1] = guess_i.slot_1;
    assign guess_c[2] = guess_i.slot_2;
    assign guess_c[3] = guess_i.slot_3;

    for (genvar k = 0; k < PEGS_PER_ROW; k++) begin : g_exact
        assign exact[k] = (code_c[k] == guess_c[k]);
    end

    // Walks down so the lowest free matching slot wins
    always_comb begin
        hit      = 1'b0;
        hit_slot = '0;
        for (int j = PEGS_PER_ROW - 1; j >= 0; j--) begin
            if (!exact[j] && !used_q[j] && (guess_c[j] == code_c[idx_q])) begin
                hit      = 1'b1;
                hit_slot = slot_t'(j);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            busy_q  <= 1'b0;
            valid_q <= 1'b0;
            idx_q   <= '0;
            used_q  <= '0;
            fb_q    <= '0;
        end else begin
            valid_q <= 1'b0;
            if (start_i) begin
                busy_q <= 1'b1;
                idx_q  <= '0;
                used_q <= '0;
                fb_q   <= '0;
            end else if (busy_q) begin
                if (exact[idx_q]) begin
                    fb_q.red <= fb_q.red + 3'd1;
                end else if (hit) begin
                    used_q[hit_slot] <= 1'b1;
                    fb_q.white       <= fb_q.white + 3'd1;
                end
                idx_q <= idx_q + 2'd1;
                if (idx_q == slot_t'(PEGS_PER_ROW - 1)) begin
                    busy_q  <= 1'b0;
                    valid_q <= 1'b1;   // Fifth cycle after start
                end
            end
        end
    end

    assign feedback_o    = fb_q;
    assign score_valid_o = valid_q;

    a_peg_total: assert property (
        @(posedge clock) disable iff (!resetn)
        score_valid_o |-> (feedback_o.red + feedback_o.white <= PEGS_PER_ROW)
    );

endmodule

`default_nettype wire

/* src/match_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module match_tracker import mastermind_pkg::*; #(
    parameter int MAX_GUESSES = 8
) (
    input  wire        clock,
    input  wire        resetn,
    input  feedback_t  feedback_i,
    input  wire        score_valid_i,
    output logic       game_end_o,
    output guess_idx_t guess_count_o,
    output score_t     score_one_o,
    output score_t     score_two_o,
    output logic       one_sets_code_o
);

    localparam guess_idx_t LAST_GUESS = guess_idx_t'(MAX_GUESSES - 1);

    guess_idx_t count_q;
    score_t     score_one_q;
    score_t     score_two_q;
    logic       one_sets_q;
    logic       win;

    assign win        = (feedback_i.red == peg_count_t'(PEGS_PER_ROW));
    assign game_end_o = score_valid_i && (win || (count_q == LAST_GUESS));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            count_q     <= '0;
            score_one_q <= '0;
            score_two_q <= '0;
            one_sets_q  <= 1'b1;
        end else if (score_valid_i) begin
            if (!win) begin   // Setter is paid for every miss
                if (one_sets_q) begin
                    score_one_q <= score_one_q + 4'd1;
                end else begin
                    score_two_q <= score_two_q + 4'd1;
                end
            end
            if (game_end_o) begin
                count_q    <= '0;
                one_sets_q <= !one_sets_q;   // Roles swap
            end else begin
                count_q <= count_q + 4'd1;
            end
        end
    end

    assign guess_count_o   = count_q;
    assign score_one_o     = score_one_q;
    assign score_two_o     = score_two_q;
    assign one_sets_code_o = one_sets_q;

    a_count_range: assert property (
        @(posedge clock) disable iff (!resetn)
        guess_count_o < MAX_GUESSES
    );

endmodule

`default_nettype wire

/* src/mastermind_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mastermind_top import mastermind_pkg::*; #(
    parameter int MAX_GUESSES = 8
) (
    input  wire        clock,
    input  wire        resetn,
    input  colour_t    colour_i,
    input  wire        load_i,
    output feedback_t  feedback_o,
    output logic       score_valid_o,
    output guess_idx_t guess_count_o,
    output score_t     score_one_o,
    output score_t     score_two_o,
    output logic       one_sets_code_o
);

    logic     write_code;
    logic     write_guess;
    slot_t    slot;
    logic     score_start;
    logic     game_end;
    peg_row_t code;
    peg_row_t guess;

    peg_entry_fsm u_peg_entry_fsm (
        .clock         (clock),
        .resetn        (resetn),
        .load_i        (load_i),
        .game_end_i    (game_end),
        .write_code_o  (write_code),
        .write_guess_o (write_guess),
        .slot_o        (slot),
        .score_start_o (score_start)
    );

    peg_store u_peg_store (
        .clock         (clock),
        .resetn        (resetn),
        .colour_i      (colour_i),
        .write_code_i  (write_code),
        .write_guess_i (write_guess),
        .slot_i        (slot),
        .code_o        (code),
        .guess_o       (guess)
    );

    peg_scorer u_peg_scorer (
        .clock         (clock),
        .resetn        (resetn),
        .start_i       (score_start),
        .code_i        (code),
        .guess_i       (guess),
        .feedback_o    (feedback_o),
        .score_valid_o (score_valid_o)
    );

    match_tracker #(
        .MAX_GUESSES (MAX_GUESSES)
    ) u_match_tracker (
        .clock           (clock),
        .resetn          (resetn),
        .feedback_i      (feedback_o),
        .score_valid_i   (score_valid_o),
        .game_end_o      (game_end),
        .guess_count_o   (guess_count_o),
        .score_one_o     (score_one_o),
        .score_two_o     (score_two_o),
        .one_sets_code_o (one_sets_code_o)
    );

endmodule

`default_nettype wire

/* bench/mastermind_model.svh */
`ifndef MASTERMIND_MODEL_SVH
`define MASTERMIND_MODEL_SVH

// Expected match state
int exp_count;
int exp_score_one;
int exp_score_two;
bit exp_one_sets;

function automatic void model_feedback(input int code_p [4], input int guess_p [4],
                                       output int red, output int white);
    int i;
    int c;
    int in_code;
    int in_guess;
    int common;
    red    = 0;
    common = 0;
    for (i = 0; i < 4; i++) begin
        if (code_p[i] == guess_p[i]) red++;
    end
    // Colour overlap over all eight colours
    for (c = 0; c < 8; c++) begin
        in_code  = 0;
        in_guess = 0;
        for (i = 0; i < 4; i++) begin
            if (code_p[i] == c) in_code++;
            if (guess_p[i] == c) in_guess++;
        end
        common += (in_code < in_guess) ? in_code : in_guess;
    end
    white = common - red;
endfunction

task automatic model_reset();
    exp_count     = 0;
    exp_score_one = 0;
    exp_score_two = 0;
    exp_one_sets  = 1'b1;
endtask

task automatic model_update(input int red, input int max_guesses, output bit game_over);
    game_over = (red == 4) || (exp_count + 1 == max_guesses);
    if (red != 4) begin   // Setter earns a point per miss
        if (exp_one_sets) exp_score_one = (exp_score_one + 1) % 16;
        else exp_score_two = (exp_score_two + 1) % 16;
    end
    if (game_over) begin
        exp_count    = 0;
        exp_one_sets = !exp_one_sets;
    end else begin
        exp_count++;
    end
endtask

`endif

/* bench/tb_mastermind.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mastermind import mastermind_pkg::*; ();

    localparam int MAX_GUESSES   = 8;
    localparam int GAMES         = 12;
    localparam int VALID_LATENCY = 6;     // Release edge to score_valid cycle
    localparam int MAX_CYCLES    = 6000;  // 12 x 8 x 8 x 7 plus margin

    logic       clock;
    logic       resetn;
    colour_t    colour;
    logic       load;
    feedback_t  feedback;
    logic       score_valid;
    guess_idx_t guess_count;
    score_t     score_one;
    score_t     score_two;
    logic       one_sets_code;

    integer seed;
    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;
    int     code_pegs [4];
    int     guess_pegs [4];
    bit     game_over;

    `include "mastermind_model.svh"

    mastermind_top #(
        .MAX_GUESSES (MAX_GUESSES)
    ) u_mastermind_top (
        .clock           (clock),
        .resetn          (resetn),
        .colour_i        (colour),
        .load_i          (load),
        .feedback_o      (feedback),
        .score_valid_o   (score_valid),
        .guess_count_o   (guess_count),
        .score_one_o     (score_one),
        .score_two_o     (score_two),
        .one_sets_code_o (one_sets_code)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            $display("Timeout: the games did not finish within %0d cycles", MAX_CYCLES);
            error_count++;
            finish_run();
        end
    end

    // Returns at the edge where load drops
    task automatic hold_press(input int c);
        int hold;
        hold = 1 + rand_below(3);
        colour <= colour_t'(c);
        load   <= 1'b1;
        repeat (hold) @(posedge clock);
        load <= 1'b0;
    endtask

    task automatic press(input int c);
        int gap;
        gap = 1 + rand_below(3);
        hold_press(c);
        repeat (gap) @(posedge clock);
    endtask

    task automatic enter_code();
        int i;
        for (i = 0; i < 4; i++) begin
            code_pegs[i] = rand_below(8);
            press(code_pegs[i]);
        end
    endtask

    task automatic play_guess();
        int i;
        int edges;
        int noise_at;
        int noise_len;
        int exp_red;
        int exp_white;
        bit copy;
        copy = (rand_below(4) == 0);   // Lets some games end early
        for (i = 0; i < 4; i++) begin
            guess_pegs[i] = copy ? code_pegs[i] : rand_below(8);
        end
        for (i = 0; i < 3; i++) begin
            press(guess_pegs[i]);
        end
        hold_press(guess_pegs[3]);
        model_feedback(code_pegs, guess_pegs, exp_red, exp_white);
        noise_at  = 1 + rand_below(2);
        noise_len = 1 + rand_below(3);
        edges     = 0;
        @(negedge clock);
        while (!score_valid && edges < 2 * VALID_LATENCY) begin
            @(posedge clock);
            edges++;
            if (edges == noise_at) begin   // Stray press while scoring
                colour <= colour_t'(rand_below(8));
                load   <= 1'b1;
            end else if (edges == noise_at + noise_len) begin
                load <= 1'b0;
            end
            @(negedge clock);
        end
        check_value("score_valid_o latency", VALID_LATENCY, edges);
        check_value("feedback_o.red", exp_red, int'(feedback.red));
        check_value("feedback_o.white", exp_white, int'(feedback.white));
        model_update(exp_red, MAX_GUESSES, game_over);
        @(posedge clock);
        @(negedge clock);
        check_value("score_valid_o", 0, int'(score_valid));
        check_value("guess_count_o", exp_count, int'(guess_count));
        check_value("score_one_o", exp_score_one, int'(score_one));
        check_value("score_two_o", exp_score_two, int'(score_two));
        check_value("one_sets_code_o", int'(exp_one_sets), int'(one_sets_code));
        @(posedge clock);
    endtask

    initial begin
        int game;
        seed = 73;
        resetn <= 1'b0;
        load   <= 1'b0;
        colour <= '0;
        model_reset();
        repeat (4) @(posedge clock);
        resetn <= 1'b1;
        @(negedge clock);
        check_value("score_valid_o", 0, int'(score_valid));
        check_value("feedback_o", 0, int'(feedback));
        check_value("guess_count_o", 0, int'(guess_count));
        check_value("score_one_o", 0, int'(score_one));
        check_value("score_two_o", 0, int'(score_two));
        check_value("one_sets_code_o", 1, int'(one_sets_code));
        @(posedge clock);
        for (game = 0; game < GAMES; game++) begin
            enter_code();
            game_over = 1'b0;
            while (!game_over) begin
                play_guess();
            end
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+bench
src/mastermind_pkg.sv
src/peg_entry_fsm.sv
src/peg_store.sv
src/peg_scorer.sv
src/match_tracker.sv
src/mastermind_top.sv
bench/tb_mastermind.sv

/* Makefile */
SOURCES = $(wildcard src/*.sv) bench/tb_mastermind.sv bench/mastermind_model.svh

obj_dir/Vtb_mastermind: filelist.f $(SOURCES)
	verilator --binary --timing --assert -f filelist.f --top-module tb_mastermind

run: obj_dir/Vtb_mastermind
	./obj_dir/Vtb_mastermind | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
